// ==== design/alu.sv ====
`timescale 1ns/10ps

module alu
    import exe_pkg::*;
(
    input  exe_op_e         op,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0]     sum;
    logic [LOG_XLEN-1:0] shamt;

    assign sum   = src1 + src2;
    assign shamt = src2[LOG_XLEN-1:0];

    always_comb begin
        case (op)
            op_add: begin
                result = sum;
            end
            op_sub: begin
                result = src1 - src2;
            end
            op_slt: begin
                result = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            op_sltu: begin
                result = {{(XLEN-1){1'b0}}, src1 < src2};
            end
            op_and: begin
                result = src1 & src2;
            end
            op_or: begin
                result = src1 | src2;
            end
            op_xor: begin
                result = src1 ^ src2;
            end
            op_sll: begin
                result = src1 << shamt;
            end
            op_srl: begin
                result = src1 >> shamt;
            end
            op_sra: begin
                result = $unsigned($signed(src1) >>> shamt);
            end
            op_lui: begin
                result = src2;
            end
            // loads and stores need the virtual address
            default: begin
                result = sum;
            end
        endcase
    end

endmodule

// ==== design/div_dispatch.sv ====
`timescale 1ns/10ps

module div_dispatch
    import exe_pkg::*;
(
    input  logic               clk,
    input  logic               resetn,
    input  logic               valid,
    input  exe_in_t            inst,
    input  logic [NUM_DIV-1:0] done,
    input  logic               mem_allowin,
    output logic [NUM_DIV-1:0] start,
    output logic [XLEN-1:0]    dividend,
    output logic [XLEN-1:0]    divisor,
    output logic               div_done
);

    logic                 issued;
    logic                 is_div;
    logic [DIV_IDX_W-1:0] unit;

    assign is_div   = is_div_op(inst.op);
    assign unit     = div_unit(inst.op);
    assign dividend = inst.src1;
    assign divisor  = inst.src2;

    // one start per instruction
    always_comb begin
        start = '0;
        if (valid && is_div && !issued) begin
            start[unit] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            issued   <= 1'b0;
            div_done <= 1'b0;
        end else if (valid && div_done && mem_allowin) begin
            issued   <= 1'b0;
            div_done <= 1'b0;
        end else begin
            if (|start) begin
                issued <= 1'b1;
            end
            if (issued && done[unit]) begin
                div_done <= 1'b1;
            end
        end
    end

endmodule

// ==== design/exe_pkg.sv ====
package exe_pkg;

    localparam int XLEN       = 32;
    localparam int LOG_XLEN   = $clog2(XLEN);
    localparam int NUM_DIV    = 2;
    localparam int DIV_IDX_W  = (NUM_DIV > 1) ? $clog2(NUM_DIV) : 1;
    localparam int DIV_CYCLES = 33;

    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    typedef enum logic [4:0] {
        op_add, op_sub, op_slt, op_sltu, op_and, op_or, op_xor,
        op_sll, op_srl, op_sra, op_lui,
        op_div, op_mod, op_divu, op_modu,
        op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w,
        op_st_b, op_st_h, op_st_w
    } exe_op_e;

    typedef enum logic [1:0] {
        exc_none,
        exc_ale,
        exc_adem
    } exc_e;

    typedef struct packed {
        exe_op_e         op;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
        logic [XLEN-1:0] rkd_value;
        logic [4:0]      dest;
        logic            gr_we;
    } exe_in_t;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic [4:0]      dest;
        logic            gr_we;
        logic            is_load;
        logic            is_store;
        logic            cancelled;
        exc_e            exc;
    } exe_out_t;

    typedef struct packed {
        logic            req;
        logic            wr;
        logic [1:0]      size;
        logic [XLEN-1:0] addr;
        logic [3:0]      wstrb;
        logic [XLEN-1:0] wdata;
    } sram_req_t;

    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic [1:0] mat;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_cfg_t;

    typedef struct packed {
        logic       da;
        logic       pg;
        logic [1:0] plv;
    } mode_t;

    function automatic logic is_load_op(exe_op_e op);
        return op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};
    endfunction

    function automatic logic is_store_op(exe_op_e op);
        return op inside {op_st_b, op_st_h, op_st_w};
    endfunction

    function automatic logic is_div_op(exe_op_e op);
        return op inside {op_div, op_mod, op_divu, op_modu};
    endfunction

    function automatic logic is_rem_op(exe_op_e op);
        return op inside {op_mod, op_modu};
    endfunction

    // unit 0 signed, unit 1 unsigned
    function automatic logic [DIV_IDX_W-1:0] div_unit(exe_op_e op);
        return (op inside {op_div, op_mod}) ? DIV_IDX_W'(0) : DIV_IDX_W'(1);
    endfunction

endpackage

// ==== design/exe_stage.sv ====
`timescale 1ns/10ps

module exe_stage
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      id_valid,
    input  exe_in_t   id_bus,
    output logic      allowin,
    output logic      out_valid,
    output exe_out_t  out_bus,
    input  logic      mem_allowin,
    output sram_req_t sram,
    input  logic      addr_ok,
    input  logic      flush,
    input  mode_t     mode,
    input  dmw_cfg_t  dmw0,
    input  dmw_cfg_t  dmw1
);

    logic                           valid;
    exe_in_t                        inst;
    logic                           flushing;
    logic                           ready_go;
    logic [XLEN-1:0]                alu_result;
    logic [NUM_DIV-1:0]             start;
    logic [NUM_DIV-1:0]             done;
    logic [XLEN-1:0]                dividend;
    logic [XLEN-1:0]                divisor;
    logic                           div_done;
    logic [NUM_DIV-1:0][XLEN-1:0]   quotient;
    logic [NUM_DIV-1:0][XLEN-1:0]   remainder;
    exc_e                           exc;
    logic                           mem_done;
    logic                           cancelled;

    stage_ctrl u_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .id_valid    (id_valid),
        .id_bus      (id_bus),
        .mem_allowin (mem_allowin),
        .flush       (flush),
        .op_done     (ready_go),
        .allowin     (allowin),
        .valid       (valid),
        .inst        (inst),
        .flushing    (flushing)
    );

    alu u_alu (
        .op     (inst.op),
        .src1   (inst.src1),
        .src2   (inst.src2),
        .result (alu_result)
    );

    div_dispatch u_dispatch (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .inst        (inst),
        .done        (done),
        .mem_allowin (mem_allowin),
        .start       (start),
        .dividend    (dividend),
        .divisor     (divisor),
        .div_done    (div_done)
    );

    for (genvar i = 0; i < NUM_DIV; i++) begin : g_div
        seq_divider #(
            .SIGNED (i == 0)
        ) u_div (
            .clk       (clk),
            .resetn    (resetn),
            .start     (start[i]),
            .dividend  (dividend),
            .divisor   (divisor),
            .done      (done[i]),
            .quotient  (quotient[i]),
            .remainder (remainder[i])
        );
    end

    mem_access u_mem (
        .valid       (valid),
        .inst        (inst),
        .vaddr       (alu_result),
        .mode        (mode),
        .dmw0        (dmw0),
        .dmw1        (dmw1),
        .mem_allowin (mem_allowin),
        .flushing    (flushing),
        .addr_ok     (addr_ok),
        .sram        (sram),
        .exc         (exc),
        .mem_done    (mem_done)
    );

    result_select u_sel (
        .inst       (inst),
        .alu_result (alu_result),
        .quotient   (quotient),
        .remainder  (remainder),
        .exc        (exc),
        .cancelled  (cancelled),
        .out_bus    (out_bus)
    );

    // ready_go by op group
    assign ready_go  = is_div_op(inst.op) ? div_done :
                       (is_load_op(inst.op) || is_store_op(inst.op)) ? mem_done : 1'b1;
    assign cancelled = flushing || (exc != exc_none);
    assign out_valid = valid && ready_go && !flushing;

endmodule

// ==== design/mem_access.sv ====
`timescale 1ns/10ps

module mem_access
    import exe_pkg::*;
(
    input  logic            valid,
    input  exe_in_t         inst,
    input  logic [XLEN-1:0] vaddr,
    input  mode_t           mode,
    input  dmw_cfg_t        dmw0,
    input  dmw_cfg_t        dmw1,
    input  logic            mem_allowin,
    input  logic            flushing,
    input  logic            addr_ok,
    output sram_req_t       sram,
    output exc_e            exc,
    output logic            mem_done
);

    function automatic logic dmw_hit(dmw_cfg_t w, logic [1:0] plv, logic [2:0] seg);
        logic plv_ok;
        plv_ok = (plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3);
        return (seg == w.vseg) && plv_ok;
    endfunction

    logic is_load;
    logic is_store;
    logic is_mem;
    logic is_half;
    logic is_word;
    logic direct;
    logic hit0;
    logic hit1;
    logic ale;
    logic adem;
    logic cancel;

    assign is_load  = is_load_op(inst.op);
    assign is_store = is_store_op(inst.op);
    assign is_mem   = is_load || is_store;
    assign is_half  = inst.op inside {op_ld_h, op_ld_hu, op_st_h};
    assign is_word  = inst.op inside {op_ld_w, op_st_w};

    assign direct = mode.da && !mode.pg;
    assign hit0   = dmw_hit(dmw0, mode.plv, vaddr[XLEN-1 -: 3]);
    assign hit1   = dmw_hit(dmw1, mode.plv, vaddr[XLEN-1 -: 3]);

    // no paging, so a window miss outside direct mode is fatal
    assign ale  = is_mem && ((is_half && vaddr[0]) || (is_word && |vaddr[1:0]));
    assign adem = is_mem && !hit0 && !hit1
                  && (!direct || (mode.plv == 2'd3 && vaddr[XLEN-1]));
    assign exc  = ale ? exc_ale : adem ? exc_adem : exc_none;

    assign cancel   = flushing || (exc != exc_none);
    assign mem_done = (sram.req && addr_ok) || cancel;

    always_comb begin
        sram.req = valid && is_mem && mem_allowin && !cancel;
        sram.wr  = is_store;

        if (direct) begin
            sram.addr = vaddr;
        end else if (hit0) begin
            sram.addr = {dmw0.pseg, vaddr[XLEN-4:0]};
        end else if (hit1) begin
            sram.addr = {dmw1.pseg, vaddr[XLEN-4:0]};
        end else begin
            sram.addr = vaddr;
        end

        sram.size = is_word ? SIZE_WORD : is_half ? SIZE_HALF : SIZE_BYTE;

        case (inst.op)
            op_st_b: begin
                sram.wstrb = 4'b0001 << vaddr[1:0];
                sram.wdata = {4{inst.rkd_value[7:0]}};
            end
            op_st_h: begin
                sram.wstrb = 4'b0011 << {vaddr[1], 1'b0};
                sram.wdata = {2{inst.rkd_value[15:0]}};
            end
            op_st_w: begin
                sram.wstrb = 4'b1111;
                sram.wdata = inst.rkd_value;
            end
            default: begin
                sram.wstrb = 4'b0000;
                sram.wdata = inst.rkd_value;
            end
        endcase
    end

endmodule

// ==== design/result_select.sv ====
`timescale 1ns/10ps

module result_select
    import exe_pkg::*;
(
    input  exe_in_t                      inst,
    input  logic [XLEN-1:0]              alu_result,
    input  logic [NUM_DIV-1:0][XLEN-1:0] quotient,
    input  logic [NUM_DIV-1:0][XLEN-1:0] remainder,
    input  exc_e                         exc,
    input  logic                         cancelled,
    output exe_out_t                     out_bus
);

    logic [DIV_IDX_W-1:0] unit;
    logic [XLEN-1:0]      div_result;

    assign unit       = div_unit(inst.op);
    assign div_result = is_rem_op(inst.op) ? remainder[unit] : quotient[unit];

    always_comb begin
        out_bus.result    = is_div_op(inst.op) ? div_result : alu_result;
        out_bus.dest      = inst.dest;
        out_bus.gr_we     = inst.gr_we;
        out_bus.is_load   = is_load_op(inst.op);
        out_bus.is_store  = is_store_op(inst.op);
        out_bus.cancelled = cancelled;
        out_bus.exc       = exc;
    end

endmodule

// ==== design/seq_divider.sv ====
`timescale 1ns/10ps

module seq_divider
    import exe_pkg::*;
#(
    parameter bit SIGNED = 1'b1
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            start,
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    output logic            done,
    output logic [XLEN-1:0] quotient,
    output logic [XLEN-1:0] remainder
);

    localparam logic [LOG_XLEN-1:0] LAST_STEP = LOG_XLEN'(DIV_CYCLES - 2);

    logic                busy;
    logic [LOG_XLEN-1:0] cnt;
    logic [XLEN-1:0]     acc_rem;
    logic [XLEN-1:0]     acc_quo;
    logic [XLEN-1:0]     dvsr_mag;
    logic [XLEN-1:0]     dvnd_save;
    logic                neg_q;
    logic                neg_r;
    logic                by_zero;
    logic                a_neg;
    logic                b_neg;
    logic [XLEN-1:0]     a_mag;
    logic [XLEN-1:0]     b_mag;
    logic [XLEN:0]       trial;
    logic [XLEN:0]       diff;
    logic                fits;
    logic [XLEN-1:0]     rem_next;
    logic [XLEN-1:0]     quo_next;

    assign a_neg = SIGNED && dividend[XLEN-1];
    assign b_neg = SIGNED && divisor[XLEN-1];
    assign a_mag = a_neg ? -dividend : dividend;
    assign b_mag = b_neg ? -divisor : divisor;

    // one restoring step, dividend bits shift in from acc_quo
    assign trial    = {acc_rem, acc_quo[XLEN-1]};
    assign diff     = trial - {1'b0, dvsr_mag};
    assign fits     = !diff[XLEN];
    assign rem_next = fits ? diff[XLEN-1:0] : trial[XLEN-1:0];
    assign quo_next = {acc_quo[XLEN-2:0], fits};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == LAST_STEP) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc_rem   <= '0;
            acc_quo   <= a_mag;
            dvsr_mag  <= b_mag;
            dvnd_save <= dividend;
            neg_q     <= a_neg ^ b_neg;
            neg_r     <= a_neg;
            by_zero   <= (divisor == '0);
        end else if (busy) begin
            acc_rem <= rem_next;
            acc_quo <= quo_next;
            if (cnt == LAST_STEP) begin
                // remainder follows the dividend sign
                quotient  <= by_zero ? '1 : (neg_q ? -quo_next : quo_next);
                remainder <= by_zero ? dvnd_save : (neg_r ? -rem_next : rem_next);
            end
        end
    end

endmodule

// ==== design/stage_ctrl.sv ====
`timescale 1ns/10ps

module stage_ctrl
    import exe_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    id_valid,
    input  exe_in_t id_bus,
    input  logic    mem_allowin,
    input  logic    flush,
    input  logic    op_done,
    output logic    allowin,
    output logic    valid,
    output exe_in_t inst,
    output logic    flushing
);

    logic flush_r;
    logic capture;

    assign allowin  = (op_done && mem_allowin) || !valid;
    assign capture  = id_valid && allowin;
    assign flushing = flush || flush_r;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            inst <= id_bus;
        end
    end

    // flush in the capture cycle also kills the new instruction
    always_ff @(posedge clk) begin
        if (!resetn) begin
            flush_r <= 1'b0;
        end else if (flush) begin
            flush_r <= 1'b1;
        end else if (capture) begin
            flush_r <= 1'b0;
        end
    end

endmodule

// ==== flist.f ====
+incdir+test
design/exe_pkg.sv
design/stage_ctrl.sv
design/alu.sv
design/div_dispatch.sv
design/seq_divider.sv
design/mem_access.sv
design/result_select.sv
design/exe_stage.sv
test/tb_exe_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f flist.f --top-module tb_exe_stage -o sim_exe_stage

# the testbench ends with a nonzero status on failure, the log decides
./obj_dir/sim_exe_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// ==== test/tb_exe_table.svh ====
// columns: op, src1, src2, rkd_value, mode, flush at capture,
// then expected result, addr, wstrb, size, wdata and exc
typedef struct {
    exe_op_e         op;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] rkd;
    mode_t           mode;
    logic            flush;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] addr;
    logic [3:0]      wstrb;
    logic [1:0]      size;
    logic [XLEN-1:0] wdata;
    exc_e            exc;
} vec_t;

// windows stay fixed: 0 maps seg 5 to 0 for plv0, 1 maps seg 4 to 1 for plv3
localparam dmw_cfg_t WIN0  = '{plv0: 1'b1, plv3: 1'b0, mat: 2'd1, pseg: 3'd0, vseg: 3'd5};
localparam dmw_cfg_t WIN1  = '{plv0: 1'b0, plv3: 1'b1, mat: 2'd0, pseg: 3'd1, vseg: 3'd4};
localparam mode_t    M_DA  = 4'b1000;
localparam mode_t    M_PG0 = 4'b0100;
localparam mode_t    M_PG3 = 4'b0111;

localparam int NUM_VECS = 38;

vec_t vecs [NUM_VECS] = '{
    '{op_add,  'h5, 'h7, 'h0, M_DA, 1'b0, 'hc, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_sub,  'h3, 'h5, 'h0, M_DA, 1'b0, 'hfffffffe, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_slt,  'hffffffff, 'h1, 'h0, M_DA, 1'b0, 'h1, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_sltu, 'hffffffff, 'h1, 'h0, M_DA, 1'b0, 'h0, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_and,  'hf0f0f0f0, 'hff00ff00, 'h0, M_DA, 1'b0, 'hf000f000, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_or,   'hf0f0f0f0, 'h0f000000, 'h0, M_DA, 1'b0, 'hfff0f0f0, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_xor,  'hffff0000, 'h0f0f0f0f, 'h0, M_DA, 1'b0, 'hf0f00f0f, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_sll,  'h1, 'h24, 'h0, M_DA, 1'b0, 'h10, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_srl,  'h80000000, 'h4, 'h0, M_DA, 1'b0, 'h08000000, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_sra,  'h80000000, 'h4, 'h0, M_DA, 1'b0, 'hf8000000, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_lui,  'h1234, 'habcde000, 'h0, M_DA, 1'b0, 'habcde000, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_div,  'hfffffff9, 'h2, 'h0, M_DA, 1'b0, 'hfffffffd, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_mod,  'hfffffff9, 'h2, 'h0, M_DA, 1'b0, 'hffffffff, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_divu, 'hfffffff9, 'h2, 'h0, M_DA, 1'b0, 'h7ffffffc, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_modu, 'hfffffff9, 'h2, 'h0, M_DA, 1'b0, 'h1, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_div,  'h64, 'h0, 'h0, M_DA, 1'b0, 'hffffffff, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_modu, 'h64, 'h0, 'h0, M_DA, 1'b0, 'h64, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_div,  'h80000000, 'hffffffff, 'h0, M_DA, 1'b0, 'h80000000, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_mod,  'h80000000, 'hffffffff, 'h0, M_DA, 1'b0, 'h0, 'h0, 4'h0, 2'd0, 'h0, exc_none},
    '{op_st_b, 'h1000, 'h0, 'h123456a5, M_DA, 1'b0, 'h1000, 'h1000, 4'h1, 2'd0, 'ha5a5a5a5, exc_none},
    '{op_st_b, 'h1000, 'h1, 'h123456a5, M_DA, 1'b0, 'h1001, 'h1001, 4'h2, 2'd0, 'ha5a5a5a5, exc_none},
    '{op_st_b, 'h1000, 'h2, 'h123456a5, M_DA, 1'b0, 'h1002, 'h1002, 4'h4, 2'd0, 'ha5a5a5a5, exc_none},
    '{op_st_b, 'h1000, 'h3, 'h123456a5, M_DA, 1'b0, 'h1003, 'h1003, 4'h8, 2'd0, 'ha5a5a5a5, exc_none},
    '{op_st_h, 'h1000, 'h0, 'h123456a5, M_DA, 1'b0, 'h1000, 'h1000, 4'h3, 2'd1, 'h56a556a5, exc_none},
    '{op_st_h, 'h1000, 'h2, 'h123456a5, M_DA, 1'b0, 'h1002, 'h1002, 4'hc, 2'd1, 'h56a556a5, exc_none},
    '{op_st_w, 'h1000, 'h0, 'h123456a5, M_DA, 1'b0, 'h1000, 'h1000, 4'hf, 2'd2, 'h123456a5, exc_none},
    '{op_ld_b,  'h2000, 'h3, 'h0, M_DA, 1'b0, 'h2003, 'h2003, 4'h0, 2'd0, 'h0, exc_none},
    '{op_ld_bu, 'h2000, 'h1, 'h0, M_DA, 1'b0, 'h2001, 'h2001, 4'h0, 2'd0, 'h0, exc_none},
    '{op_ld_h,  'h2000, 'h2, 'h0, M_DA, 1'b0, 'h2002, 'h2002, 4'h0, 2'd1, 'h0, exc_none},
    '{op_ld_hu, 'h2000, 'h0, 'h0, M_DA, 1'b0, 'h2000, 'h2000, 4'h0, 2'd1, 'h0, exc_none},
    '{op_ld_w,  'h2000, 'h4, 'h0, M_DA, 1'b0, 'h2004, 'h2004, 4'h0, 2'd2, 'h0, exc_none},
    '{op_ld_w, 'ha0001000, 'h4, 'h0, M_PG0, 1'b0, 'ha0001004, 'h00001004, 4'h0, 2'd2, 'h0, exc_none},
    '{op_st_w, 'h80002000, 'h8, 'h11223344, M_PG3, 1'b0, 'h80002008, 'h20002008, 4'hf, 2'd2,
      'h11223344, exc_none},
    '{op_ld_w, 'ha0000000, 'h10, 'h0, M_PG3, 1'b0, 'ha0000010, 'h0, 4'h0, 2'd2, 'h0, exc_adem},
    '{op_ld_h, 'h3000, 'h1, 'h0, M_DA, 1'b0, 'h3001, 'h0, 4'h0, 2'd1, 'h0, exc_ale},
    '{op_st_w, 'h3000, 'h2, 'h55, M_DA, 1'b0, 'h3002, 'h0, 4'h0, 2'd2, 'h0, exc_ale},
    '{op_ld_w,  'h4000, 'h0, 'h0, M_DA, 1'b1, 'h4000, 'h4000, 4'h0, 2'd2, 'h0, exc_none},
    '{op_add,  'h10, 'h20, 'h0, M_DA, 1'b0, 'h30, 'h0, 4'h0, 2'd0, 'h0, exc_none}
};

// ==== test/tb_exe_stage.sv ====
`timescale 1ns/10ps

module tb_exe_stage
    import exe_pkg::*;
();

    logic      clk;
    logic      resetn;
    logic      id_valid;
    exe_in_t   id_bus;
    logic      allowin;
    logic      out_valid;
    exe_out_t  out_bus;
    logic      mem_allowin;
    sram_req_t sram;
    logic      addr_ok;
    logic      flush;
    mode_t     mode;
    dmw_cfg_t  dmw0;
    dmw_cfg_t  dmw1;

    logic [31:0] seed;
    int          cycles;

`include "tb_exe_table.svh"

    localparam int MAX_CYCLES = NUM_VECS * 4 * (DIV_CYCLES + 4);

    exe_stage dut0 (
        .clk         (clk),
        .resetn      (resetn),
        .id_valid    (id_valid),
        .id_bus      (id_bus),
        .allowin     (allowin),
        .out_valid   (out_valid),
        .out_bus     (out_bus),
        .mem_allowin (mem_allowin),
        .sram        (sram),
        .addr_ok     (addr_ok),
        .flush       (flush),
        .mode        (mode),
        .dmw0        (dmw0),
        .dmw1        (dmw1)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic stop_on_error();
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error: time %0t, %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("at time %0t: %s", $time, what);
            stop_on_error();
        end
    endtask

    // new cycle, back-pressure and addr_ok rerolled just after the edge
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk);
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout, the stage stopped making progress after %0d cycles", cycles);
            stop_on_error();
        end else begin
            #1;
            r = lcg_next();
            mem_allowin = r[16];
            r = lcg_next();
            addr_ok = r[16];
        end
    endtask

    task automatic run_vec(input vec_t v, input int idx);
        logic       is_load;
        logic       is_store;
        logic       is_mem;
        logic [4:0] dest;
        logic       gr_we;
        logic       seen_req;
        logic       finished;
        logic       have_prev;
        exe_out_t   prev_bus;
        is_load   = v.op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};
        is_store  = v.op inside {op_st_b, op_st_h, op_st_w};
        is_mem    = is_load || is_store;
        dest      = 5'(idx + 1);
        gr_we     = idx[0];
        seen_req  = 1'b0;
        finished  = 1'b0;
        have_prev = 1'b0;
        prev_bus  = '0;

        next_cycle();
        id_valid        = 1'b1;
        id_bus.op       = v.op;
        id_bus.src1     = v.src1;
        id_bus.src2     = v.src2;
        id_bus.rkd_value = v.rkd;
        id_bus.dest     = dest;
        id_bus.gr_we    = gr_we;
        mode            = v.mode;
        flush           = v.flush;
        @(negedge clk);
        while (!allowin) begin
            next_cycle();
            @(negedge clk);
        end
        next_cycle();
        id_valid = 1'b0;
        flush    = 1'b0;

        if (v.flush) begin
            repeat (6) begin
                @(negedge clk);
                check_true(!out_valid, "a flushed instruction reached the output");
                check_true(!sram.req, "a flushed instruction sent a memory request");
                next_cycle();
            end
        end else begin
            while (!finished) begin
                @(negedge clk);
                if (have_prev) begin
                    assert (out_bus === prev_bus) else begin
                        $display("Error: time %0t, out_bus got %h expected %h",
                                 $time, out_bus, prev_bus);
                        stop_on_error();
                    end
                end
                if (v.exc != exc_none) begin
                    check_true(!sram.req, "a request went out for a faulting access");
                end
                if (sram.req && addr_ok) begin
                    check_true(is_mem, "a request went out for a non-memory op");
                    check_true(!seen_req, "a second request was accepted");
                    check_val("sram.addr", sram.addr, v.addr);
                    check_val("sram.wstrb", 32'(sram.wstrb), 32'(v.wstrb));
                    check_val("sram.size", 32'(sram.size), 32'(v.size));
                    check_val("sram.wdata", sram.wdata, v.wdata);
                    check_val("sram.wr", 32'(sram.wr), 32'(is_store));
                    seen_req = 1'b1;
                end
                if (out_valid && mem_allowin) begin
                    check_val("out_bus.result", out_bus.result, v.result);
                    check_val("out_bus.exc", 32'(out_bus.exc), 32'(v.exc));
                    check_val("out_bus.cancelled", 32'(out_bus.cancelled), 32'(v.exc != exc_none));
                    check_val("out_bus.dest", 32'(out_bus.dest), 32'(dest));
                    check_val("out_bus.gr_we", 32'(out_bus.gr_we), 32'(gr_we));
                    check_val("out_bus.is_load", 32'(out_bus.is_load), 32'(is_load));
                    check_val("out_bus.is_store", 32'(out_bus.is_store), 32'(is_store));
                    if (is_mem && v.exc == exc_none) begin
                        check_true(seen_req, "a memory op completed without a request");
                    end
                    finished = 1'b1;
                end else begin
                    if (out_valid) begin
                        prev_bus  = out_bus;
                        have_prev = 1'b1;
                    end
                    next_cycle();
                end
            end
        end
    endtask

    initial begin
        seed        = 32'hcb8e;
        cycles      = 0;
        resetn      = 1'b0;
        id_valid    = 1'b0;
        id_bus      = '0;
        mem_allowin = 1'b0;
        addr_ok     = 1'b0;
        flush       = 1'b0;
        mode        = M_DA;
        dmw0        = WIN0;
        dmw1        = WIN1;

        repeat (2) @(posedge clk);
        #1 resetn = 1'b1;
        @(negedge clk);
        check_val("out_valid", 32'(out_valid), 32'd0);
        check_val("sram.req", 32'(sram.req), 32'd0);

        for (int i = 0; i < NUM_VECS; i++) begin
            run_vec(vecs[i], i);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule
